//--- demo_sys_pkg.sv
package demo_sys_pkg;

  parameter int BusAw = 32;
  parameter int BusDw = 32;

  typedef logic [BusAw-1:0]   bus_addr_t;
  typedef logic [BusDw-1:0]   bus_data_t;
  typedef logic [BusDw/8-1:0] bus_be_t;

  typedef enum int {
    DevRam,
    DevGpio,
    DevTimer
  } bus_device_e;

  parameter int NrDevices = 3;

  // Device address windows
  parameter bus_addr_t RamBase   = 32'h0010_0000;
  parameter bus_addr_t RamSize   = 32'h0001_0000; // 64 KiB
  parameter bus_addr_t RamMask   = ~(RamSize - 1);

  parameter bus_addr_t GpioBase  = 32'h8000_0000;
  parameter bus_addr_t GpioSize  = 32'h0000_1000; // 4 KiB
  parameter bus_addr_t GpioMask  = ~(GpioSize - 1);

  parameter bus_addr_t TimerBase = 32'h8000_2000;
  parameter bus_addr_t TimerSize = 32'h0000_1000; // 4 KiB
  parameter bus_addr_t TimerMask = ~(TimerSize - 1);

  // Register offsets within a 4 KiB window
  parameter int RegOffW = 12;

  typedef enum logic [RegOffW-1:0] {
    GpioOut = 12'h000,
    GpioIn  = 12'h004
  } gpio_reg_e;

  typedef enum logic [RegOffW-1:0] {
    MtimeLo = 12'h000,
    MtimeHi = 12'h004,
    CmpLo   = 12'h008,
    CmpHi   = 12'h00C
  } timer_reg_e;

  // Byte-lane merge of write data into an existing word
  function automatic bus_data_t be_merge(bus_data_t old_w, bus_data_t new_w, bus_be_t be);
    bus_data_t res;
    res = old_w;
    for (int b = 0; b < BusDw / 8; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

endpackage

//--- demo_bus.sv
`timescale 1ns/1ps

module demo_bus (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  input  logic                   host_req_i,
  input  demo_sys_pkg::bus_addr_t host_addr_i,
  input  logic                   host_we_i,
  input  demo_sys_pkg::bus_be_t   host_be_i,
  input  demo_sys_pkg::bus_data_t host_wdata_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output demo_sys_pkg::bus_data_t host_rdata_o,
  output logic                   host_err_o,

  output logic                   dev_req_o    [demo_sys_pkg::NrDevices],
  output demo_sys_pkg::bus_addr_t dev_addr_o,
  output logic                   dev_we_o,
  output demo_sys_pkg::bus_be_t   dev_be_o,
  output demo_sys_pkg::bus_data_t dev_wdata_o,
  input  logic                   dev_rvalid_i [demo_sys_pkg::NrDevices],
  input  demo_sys_pkg::bus_data_t dev_rdata_i  [demo_sys_pkg::NrDevices],
  input  logic                   dev_err_i    [demo_sys_pkg::NrDevices]
);
  import demo_sys_pkg::*;

  // Window table, ordered as bus_device_e
  localparam bus_addr_t DevBase [NrDevices] = '{RamBase, GpioBase, TimerBase};
  localparam bus_addr_t DevMask [NrDevices] = '{RamMask, GpioMask, TimerMask};

  logic [NrDevices-1:0] hit;
  bus_device_e          sel_d, sel_q;
  logic                 mapped_q;
  logic                 unmapped_q;
  logic                 we_q;

  // Single host, never stalled
  assign host_gnt_o = host_req_i;

  always_comb begin
    hit   = '0;
    sel_d = DevRam;
    for (int i = 0; i < NrDevices; i++) begin
      if ((host_addr_i & DevMask[i]) == DevBase[i]) begin
        hit[i] = host_req_i;
        sel_d  = bus_device_e'(i);
      end
    end
  end

  for (genvar g = 0; g < NrDevices; g++) begin : g_dev_req
    assign dev_req_o[g] = hit[g];
  end

  assign dev_addr_o  = host_addr_i;
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_wdata_o = host_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mapped_q   <= 1'b0;
      unmapped_q <= 1'b0;
      we_q       <= 1'b0;
      sel_q      <= DevRam;
    end else begin
      mapped_q   <= |hit;
      unmapped_q <= host_req_i & ~(|hit); // Answered locally with an error
      we_q       <= host_we_i;
      if (|hit) sel_q <= sel_d;
    end
  end

  assign host_rvalid_o = unmapped_q | (mapped_q & dev_rvalid_i[sel_q]);
  assign host_err_o    = unmapped_q | (mapped_q & dev_err_i[sel_q]);
  assign host_rdata_o  = (mapped_q && !we_q) ? dev_rdata_i[sel_q] : '0;

  a_dev_req_onehot: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0(hit));

  // Device and decode paths together must keep the one-cycle response
  a_rvalid_after_gnt: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rvalid_o |-> $past(host_gnt_o));

endmodule

//--- demo_ram.sv
`timescale 1ns/1ps

module demo_ram #(
  parameter int RamDepth = 1024
) (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  input  logic                   req_i,
  input  logic                   we_i,
  input  demo_sys_pkg::bus_be_t   be_i,
  input  demo_sys_pkg::bus_addr_t addr_i,
  input  demo_sys_pkg::bus_data_t wdata_i,
  output logic                   rvalid_o,
  output demo_sys_pkg::bus_data_t rdata_o,
  output logic                   err_o
);
  import demo_sys_pkg::*;

  localparam int IdxW = $clog2(RamDepth);

  bus_data_t       mem [RamDepth];
  logic [IdxW-1:0] idx;

  assign idx = addr_i[IdxW+1:2]; // Word index, aliases inside the window

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= be_merge(mem[idx], wdata_i, be_i);
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) rvalid_o <= 1'b0;
    else             rvalid_o <= req_i;
  end

  assign err_o = 1'b0;

  a_rvalid_follows_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rvalid_o |-> $past(req_i));

endmodule

//--- demo_gpio.sv
`timescale 1ns/1ps

module demo_gpio #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  input  logic                   req_i,
  input  logic                   we_i,
  input  demo_sys_pkg::bus_be_t   be_i,
  input  demo_sys_pkg::bus_addr_t addr_i,
  input  demo_sys_pkg::bus_data_t wdata_i,
  output logic                   rvalid_o,
  output demo_sys_pkg::bus_data_t rdata_o,
  output logic                   err_o,

  input  logic [GpiWidth-1:0]    gp_i,
  output logic [GpoWidth-1:0]    gp_o
);
  import demo_sys_pkg::*;

  logic [GpiWidth-1:0] gpi_meta, gpi_sync;
  logic [RegOffW-1:0]  offset;
  logic                wr_out;

  assign offset = addr_i[RegOffW-1:0];
  assign wr_out = req_i & we_i & (offset == GpioOut);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o     <= '0;
      gpi_meta <= '0;
      gpi_sync <= '0;
      rvalid_o <= 1'b0;
    end else begin
      gpi_meta <= gp_i; // Two-flop input synchronizer
      gpi_sync <= gpi_meta;
      rvalid_o <= req_i;
      if (wr_out) gp_o <= GpoWidth'(be_merge(BusDw'(gp_o), wdata_i, be_i));
    end
  end

  // Unknown offsets read zero
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (offset)
        GpioOut: rdata_o <= BusDw'(gp_o);
        GpioIn:  rdata_o <= BusDw'(gpi_sync);
        default: rdata_o <= '0;
      endcase
    end
  end

  assign err_o = 1'b0;

endmodule

//--- demo_timer.sv
`timescale 1ns/1ps

module demo_timer (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  input  logic                   req_i,
  input  logic                   we_i,
  input  demo_sys_pkg::bus_be_t   be_i,
  input  demo_sys_pkg::bus_addr_t addr_i,
  input  demo_sys_pkg::bus_data_t wdata_i,
  output logic                   rvalid_o,
  output demo_sys_pkg::bus_data_t rdata_o,
  output logic                   err_o,
  output logic                   irq_timer_o
);
  import demo_sys_pkg::*;

  logic [63:0]        mtime_q;
  logic [63:0]        mtimecmp_q;
  logic [RegOffW-1:0] offset;
  logic               wr;
  logic               bad_off;

  assign offset = addr_i[RegOffW-1:0];
  assign wr     = req_i & we_i;

  always_comb begin
    case (offset)
      MtimeLo, MtimeHi, CmpLo, CmpHi: bad_off = 1'b0;
      default:                        bad_off = 1'b1;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1; // Keeps the interrupt quiet until programmed
    end else begin
      mtime_q <= mtime_q + 64'd1;
      if (wr) begin
        case (offset)
          MtimeLo: mtime_q[31:0]     <= be_merge(mtime_q[31:0], wdata_i, be_i);
          MtimeHi: mtime_q[63:32]    <= be_merge(mtime_q[63:32], wdata_i, be_i);
          CmpLo:   mtimecmp_q[31:0]  <= be_merge(mtimecmp_q[31:0], wdata_i, be_i);
          CmpHi:   mtimecmp_q[63:32] <= be_merge(mtimecmp_q[63:32], wdata_i, be_i);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o    <= 1'b0;
      err_o       <= 1'b0;
      irq_timer_o <= 1'b0;
    end else begin
      rvalid_o    <= req_i;
      err_o       <= req_i & bad_off;
      irq_timer_o <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (offset)
        MtimeLo: rdata_o <= mtime_q[31:0];
        MtimeHi: rdata_o <= mtime_q[63:32];
        CmpLo:   rdata_o <= mtimecmp_q[31:0];
        CmpHi:   rdata_o <= mtimecmp_q[63:32];
        default: rdata_o <= '0;
      endcase
    end
  end

  // One cycle of slack for the registered compare
  a_irq_off_when_disabled: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    (&mtimecmp_q) && $past(&mtimecmp_q) |-> !irq_timer_o);

endmodule

//--- demo_system.sv
`timescale 1ns/1ps

module demo_system #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16,
  parameter int RamDepth = 1024
) (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  input  logic                   host_req_i,
  input  demo_sys_pkg::bus_addr_t host_addr_i,
  input  logic                   host_we_i,
  input  demo_sys_pkg::bus_be_t   host_be_i,
  input  demo_sys_pkg::bus_data_t host_wdata_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output demo_sys_pkg::bus_data_t host_rdata_o,
  output logic                   host_err_o,

  input  logic [GpiWidth-1:0]    gp_i,
  output logic [GpoWidth-1:0]    gp_o,
  output logic                   irq_timer_o
);
  import demo_sys_pkg::*;

  logic      dev_req    [NrDevices];
  logic      dev_rvalid [NrDevices];
  bus_data_t dev_rdata  [NrDevices];
  logic      dev_err    [NrDevices];

  // Broadcast to all devices
  bus_addr_t dev_addr;
  logic      dev_we;
  bus_be_t   dev_be;
  bus_data_t dev_wdata;

  demo_bus u_bus (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .host_req_i   (host_req_i),
    .host_addr_i  (host_addr_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .dev_req_o    (dev_req),
    .dev_addr_o   (dev_addr),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .dev_rvalid_i (dev_rvalid),
    .dev_rdata_i  (dev_rdata),
    .dev_err_i    (dev_err)
  );

  demo_ram #(
    .RamDepth(RamDepth)
  ) u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (dev_req[DevRam]),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .addr_i    (dev_addr),
    .wdata_i   (dev_wdata),
    .rvalid_o  (dev_rvalid[DevRam]),
    .rdata_o   (dev_rdata[DevRam]),
    .err_o     (dev_err[DevRam])
  );

  demo_gpio #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (dev_req[DevGpio]),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .addr_i    (dev_addr),
    .wdata_i   (dev_wdata),
    .rvalid_o  (dev_rvalid[DevGpio]),
    .rdata_o   (dev_rdata[DevGpio]),
    .err_o     (dev_err[DevGpio]),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  demo_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[DevTimer]),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .addr_i     (dev_addr),
    .wdata_i    (dev_wdata),
    .rvalid_o   (dev_rvalid[DevTimer]),
    .rdata_o    (dev_rdata[DevTimer]),
    .err_o      (dev_err[DevTimer]),
    .irq_timer_o(irq_timer_o)
  );

endmodule

//--- tb_demo_system.sv
`timescale 1ns/1ps

module tb_demo_system;
  import demo_sys_pkg::*;

  localparam int GpiWidth  = 8;
  localparam int GpoWidth  = 16;
  localparam int RamDepth  = 1024;
  localparam int MaxCycles = 4000; // About twice the ~1800 cycles the tests take

  typedef struct {
    bus_data_t           rdata;
    logic                err;
    logic                chk;
    logic [GpoWidth-1:0] gpo;
  } exp_t;

  logic                clk_sys_i;
  logic                rst_sys_ni;
  logic                host_req_i;
  bus_addr_t           host_addr_i;
  logic                host_we_i;
  bus_be_t             host_be_i;
  bus_data_t           host_wdata_i;
  logic                host_gnt_o;
  logic                host_rvalid_o;
  bus_data_t           host_rdata_o;
  logic                host_err_o;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o;
  logic                irq_timer_o;

  exp_t                pend [$]; // Pushed with the request, popped on grant
  exp_t                head;
  bus_data_t           rd_log [$];
  logic                exp_valid_q, exp_err_q, exp_chk_q;
  bus_data_t           exp_rdata_q;
  logic [GpoWidth-1:0] gpo_q;
  int                  outstanding;
  bus_data_t           ram_model [RamDepth];
  logic [GpoWidth-1:0] gpo_model;
  integer              seed = 57496;
  int                  err_count = 0;
  int                  err_at_start = 0;
  int                  tests_done = 0;
  int                  cycles = 0;

  demo_system #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth),
    .RamDepth(RamDepth)
  ) demo_system_inst (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .host_req_i   (host_req_i),
    .host_addr_i  (host_addr_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .gp_i         (gp_i),
    .gp_o         (gp_o),
    .irq_timer_o  (irq_timer_o)
  );

  always #5 clk_sys_i = ~clk_sys_i;

  always @(posedge clk_sys_i) begin
    cycles <= cycles + 1;
    if (cycles == MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Expected response for the cycle after each request
  always @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      exp_valid_q <= 1'b0;
      exp_err_q   <= 1'b0;
      exp_chk_q   <= 1'b0;
      exp_rdata_q <= '0;
      gpo_q       <= '0;
      outstanding <= 0;
    end else begin
      exp_valid_q <= host_req_i;
      outstanding <= outstanding + int'(host_req_i) - int'(host_rvalid_o);
      if (host_rvalid_o) rd_log.push_back(host_rdata_o);
      if (host_req_i && pend.size() > 0) begin
        head = pend.pop_front();
        exp_err_q   <= head.err;
        exp_chk_q   <= head.chk;
        exp_rdata_q <= head.rdata;
        gpo_q       <= head.gpo;
      end
    end
  end

  a_gnt: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_gnt_o == host_req_i)
    else report_mismatch("host_gnt_o", 32'($sampled(host_req_i)), 32'($sampled(host_gnt_o)));

  a_rvalid: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rvalid_o == exp_valid_q)
    else report_mismatch("host_rvalid_o", 32'($sampled(exp_valid_q)),
                         32'($sampled(host_rvalid_o)));

  a_err: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    exp_valid_q |-> host_err_o == exp_err_q)
    else report_mismatch("host_err_o", 32'($sampled(exp_err_q)), 32'($sampled(host_err_o)));

  a_rdata: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    exp_valid_q && exp_chk_q |-> host_rdata_o == exp_rdata_q)
    else report_mismatch("host_rdata_o", $sampled(exp_rdata_q), $sampled(host_rdata_o));

  a_gpo: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni) gp_o == gpo_q)
    else report_mismatch("gp_o", 32'($sampled(gpo_q)), 32'($sampled(gp_o)));

  task automatic report_mismatch(string name, bus_data_t exp, bus_data_t act);
    $display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic report_failure(string what);
    $display("error at %0d ns: %s", $time, what);
    err_count++;
  endtask

  task automatic end_test(string name);
    tests_done++;
    $display("test %s done with %0d errors", name, err_count - err_at_start);
    err_at_start = err_count;
  endtask

  function automatic bus_data_t apply_bytes(bus_data_t cur, bus_data_t nw, bus_be_t be);
    bus_data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (cur & ~mask) | (nw & mask);
  endfunction

  // Called on a falling edge, returns one cycle later
  task automatic issue(logic we, bus_addr_t addr, bus_data_t wdata, bus_be_t be,
                       bus_data_t exp_rdata, logic exp_err, logic chk);
    exp_t e;
    e.rdata = we ? '0 : exp_rdata; // Writes return zero data
    e.err   = exp_err;
    e.chk   = chk;
    e.gpo   = gpo_model;
    pend.push_back(e);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_be_i    = be;
    host_wdata_i = wdata;
    @(negedge clk_sys_i);
    host_req_i = 1'b0;
  endtask

  task automatic wait_responses();
    int n;
    n = 0;
    while ((pend.size() != 0 || outstanding != 0) && n < 8) begin
      @(negedge clk_sys_i);
      n++;
    end
    if (pend.size() != 0 || outstanding != 0)
      report_failure("responses still outstanding 8 cycles after the last request");
  endtask

  task automatic ram_write(bus_addr_t addr, bus_data_t data, bus_be_t be);
    int idx;
    idx = (addr >> 2) % RamDepth;
    ram_model[idx] = apply_bytes(ram_model[idx], data, be);
    issue(1'b1, addr, data, be, '0, 1'b0, 1'b1);
  endtask

  task automatic ram_read(bus_addr_t addr);
    issue(1'b0, addr, '0, 4'hF, ram_model[(addr >> 2) % RamDepth], 1'b0, 1'b1);
  endtask

  // Back-to-back mix over 16 words and all 16 aliases of the window
  task automatic random_ram_traffic(int n);
    bus_addr_t addr;
    for (int k = 0; k < n; k++) begin
      addr = RamBase + ($unsigned($random(seed)) % 16) * RamDepth * 4
                     + ($unsigned($random(seed)) % 16) * 4;
      if ($random(seed) & 1) ram_write(addr, $random(seed), bus_be_t'($random(seed)));
      else                   ram_read(addr);
    end
  endtask

  initial begin
    bus_data_t t0, t1, thi;
    int        n;
    clk_sys_i    = 1'b0;
    rst_sys_ni   = 1'b0;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    gp_i         = '0;
    gpo_model    = '0;
    repeat (5) @(negedge clk_sys_i);
    rst_sys_ni = 1'b1;
    @(negedge clk_sys_i);

    assert (!host_rvalid_o && !host_err_o) else report_failure("bus response active after reset");
    assert (!irq_timer_o) else report_mismatch("irq_timer_o", 0, 32'(irq_timer_o));
    assert (gp_o == '0) else report_mismatch("gp_o", 0, 32'(gp_o));
    issue(1'b0, TimerBase + 32'(CmpLo), '0, 4'hF, '1, 1'b0, 1'b1);
    issue(1'b0, TimerBase + 32'(CmpHi), '0, 4'hF, '1, 1'b0, 1'b1);
    wait_responses();
    end_test("reset_state");

    for (int i = 0; i < 16; i++) begin
      ram_write(RamBase + 4 * i, (RamBase + 4 * i) * 32'h9E37_79B1, 4'hF);
    end
    ram_write(RamBase + 4, 32'h1122_3344, 4'b0001);
    ram_write(RamBase + 8, 32'hAABB_CCDD, 4'b0110);
    ram_write(RamBase + 12, 32'h5566_7788, 4'b1000);
    ram_write(RamBase + 16, 32'hCAFE_F00D, 4'b1010);
    for (int i = 0; i < 16; i++) ram_read(RamBase + 4 * i);
    ram_read(RamBase + RamDepth * 4 + 8); // Alias of word 2
    wait_responses();
    random_ram_traffic(1500);
    wait_responses();
    end_test("ram_access");

    gpo_model = GpoWidth'(apply_bytes(32'(gpo_model), 32'hA5C3_1234, 4'b0010));
    issue(1'b1, GpioBase + 32'(GpioOut), 32'hA5C3_1234, 4'b0010, '0, 1'b0, 1'b1);
    assert (gp_o == gpo_model) else report_mismatch("gp_o", 32'(gpo_model), 32'(gp_o));
    gpo_model = GpoWidth'(apply_bytes(32'(gpo_model), 32'h0000_0056, 4'b0001));
    issue(1'b1, GpioBase + 32'(GpioOut), 32'h0000_0056, 4'b0001, '0, 1'b0, 1'b1);
    issue(1'b0, GpioBase + 32'(GpioOut), '0, 4'hF, 32'(gpo_model), 1'b0, 1'b1);
    gp_i = 8'h5A;
    repeat (3) @(negedge clk_sys_i);
    issue(1'b0, GpioBase + 32'(GpioIn), '0, 4'hF, 32'h5A, 1'b0, 1'b1);
    wait_responses();
    end_test("gpio");

    rd_log.delete();
    issue(1'b0, TimerBase + 32'(MtimeLo), '0, 4'hF, '0, 1'b0, 1'b0);
    issue(1'b0, TimerBase + 32'(MtimeLo), '0, 4'hF, '0, 1'b0, 1'b0);
    issue(1'b0, TimerBase + 32'(MtimeHi), '0, 4'hF, '0, 1'b0, 1'b0);
    wait_responses();
    t0  = rd_log[0];
    t1  = rd_log[1];
    thi = rd_log[2];
    assert (t1 > t0) else report_failure("two MtimeLo reads did not increase");
    issue(1'b1, TimerBase + 32'(CmpLo), t1 + 24, 4'hF, '0, 1'b0, 1'b1);
    issue(1'b1, TimerBase + 32'(CmpHi), thi, 4'hF, '0, 1'b0, 1'b1);
    wait_responses();
    assert (!irq_timer_o) else report_failure("timer interrupt fired before mtimecmp");
    n = 0;
    while (!irq_timer_o && n < 30) begin
      @(negedge clk_sys_i);
      n++;
    end
    assert (irq_timer_o) else report_failure("timer interrupt did not rise within 30 cycles");
    issue(1'b1, TimerBase + 32'(CmpHi), '1, 4'hF, '0, 1'b0, 1'b1);
    n = 0;
    while (irq_timer_o && n < 2) begin
      @(negedge clk_sys_i);
      n++;
    end
    assert (!irq_timer_o) else report_failure("timer interrupt still high 2 cycles after disable");
    wait_responses();
    end_test("timer_irq");

    issue(1'b0, 32'h4000_0000, '0, 4'hF, '0, 1'b1, 1'b1);
    issue(1'b1, 32'h4000_0000, 32'hDEAD_BEEF, 4'hF, '0, 1'b1, 1'b1);
    issue(1'b0, TimerBase + 32'h10, '0, 4'hF, '0, 1'b1, 1'b1);
    issue(1'b1, TimerBase + 32'h10, 32'h1234_5678, 4'hF, '0, 1'b1, 1'b1);
    for (int i = 0; i < 5; i++) ram_read(RamBase + 4 * i);
    issue(1'b0, GpioBase + 32'(GpioOut), '0, 4'hF, 32'(gpo_model), 1'b0, 1'b1);
    wait_responses();
    end_test("errors");

    $display("tests %0d, errors %0d, cycles %0d", tests_done, err_count, cycles);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- demo_system.f
demo_sys_pkg.sv
demo_bus.sv
demo_ram.sv
demo_gpio.sv
demo_timer.sv
demo_system.sv
tb_demo_system.sv

//--- Bender.yml
package:
  name: demo_system

sources:
  - files:
      - demo_sys_pkg.sv
      - demo_bus.sv
      - demo_ram.sv
      - demo_gpio.sv
      - demo_timer.sv
      - demo_system.sv
  - target: test
    files:
      - tb_demo_system.sv
